// File: flist.f
+incdir+rtl
rtl/lane_pkg.sv
rtl/operand_fifo.sv
rtl/operand_queue.sv
rtl/vrf_bank.sv
rtl/operand_requester.sv
rtl/simd_alu.sv
rtl/vector_lane.sv
test/tb_clock_gen.sv
test/tb_vector_lane.sv

// File: test/lane_vectors.txt
// Each word is kind_field_data in hex, kind 1 loads data at the VRF address in field
// Kind 2 issues a command with field digits op vs1 vs2 vd vl, kind 3 queues an expected result
// Load v1 at addresses 08 to 0f and v2 at 10 to 17
1_00008_ffffffffffffffff
1_00009_0000000000000010
1_0000a_8000000000000000
1_0000b_0123456789abcdef
1_0000c_00000000000000ff
1_0000d_7fffffffffffffff
1_0000e_aaaaaaaaaaaaaaaa
1_0000f_0000000100000000
1_00010_0000000000000001
1_00011_0000000000000020
1_00012_8000000000000000
1_00013_1111111111111111
1_00014_0000000000000f00
1_00015_0000000000000001
1_00016_5555555555555555
1_00017_00000000ffffffff
// VADD v3 = v1 + v2 over all eight elements, sums wrap at 64 bits
3_00000_0000000000000000
3_00000_0000000000000030
3_00000_0000000000000000
3_00000_123456789abcdf00
3_00000_0000000000000fff
3_00000_8000000000000000
3_00000_ffffffffffffffff
3_00000_00000001ffffffff
2_01238_0000000000000000
// VSUB v4 = v1 - v2 over three elements
3_00000_fffffffffffffffe
3_00000_fffffffffffffff0
3_00000_0000000000000000
2_11243_0000000000000000
// VAND v5 = v4 & v1 reads back the VSUB result
3_00000_fffffffffffffffe
3_00000_0000000000000010
2_24152_0000000000000000
// VOR v6 = v5 | v2 with a single element
3_00000_ffffffffffffffff
2_35261_0000000000000000
// VXOR v7 = v3 ^ v4 over three elements
3_00000_fffffffffffffffe
3_00000_ffffffffffffffc0
3_00000_0000000000000000
2_43473_0000000000000000
// Zero length VADD gives no result
2_01200_0000000000000000

// File: test/tb_vector_lane.sv
// Vector lane testbench with file-driven loads and commands, random result stalls and result checks
`timescale 1ns/10ps
`include "lane_defines.svh"

module tb_vector_lane;

  localparam int unsigned NrVectors     = 64;
  localparam int unsigned ResetTimeout  = 40;
  localparam int unsigned ResultTimeout = 200;
  localparam int unsigned IdleTimeout   = 50;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    load_valid_i;
  logic [`LANE_VRF_AW-1:0] load_addr_i;
  lane_pkg::elen_t         load_data_i;
  logic                    cmd_valid_i;
  lane_pkg::lane_cmd_t     cmd_i;
  logic                    result_ready_i;
  logic                    busy_o;
  lane_pkg::elen_t         result_o;
  logic                    result_valid_o;

  // Vector word holds a kind nibble, a 20 bit field and 64 bit data
  logic [87:0]     vec_mem [NrVectors];
  lane_pkg::elen_t exp_q [$];
  int unsigned     cmd_count;

  tb_clock_gen clock_gen_inst (
    .clk_o (clk_i),
    .rst_no(rst_ni)
  );

  vector_lane vector_lane_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .load_valid_i  (load_valid_i),
    .load_addr_i   (load_addr_i),
    .load_data_i   (load_data_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_i         (cmd_i),
    .result_ready_i(result_ready_i),
    .busy_o        (busy_o),
    .result_o      (result_o),
    .result_valid_o(result_valid_o)
  );

  task automatic stop_with_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Lane testbench stopped on first error");
  endtask

  // Host stall level is high roughly three cycles in four
  initial begin
    result_ready_i = 1'b0;
    void'($urandom(40));
    forever begin
      @(negedge clk_i);
      result_ready_i = (($urandom % 4) != 0);
    end
  end

  // Result checker samples in the low phase once the stall level has settled
  always @(negedge clk_i) begin
    #20;
    if (rst_ni && result_valid_o) begin
      assert (exp_q.size() > 0) else begin
        $display("Result pulse arrived with no expected value pending");
        stop_with_failure();
      end
      assert (result_o === exp_q[0]) else begin
        $display("ERR result_o found 0x%h expected 0x%h", result_o, exp_q[0]);
        stop_with_failure();
      end
      void'(exp_q.pop_front());
    end
  end

  task automatic wait_reset_release();
    int unsigned cycles;
    cycles = 0;
    while (rst_ni !== 1'b1) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > ResetTimeout) begin
        $display("Reset was never released");
        stop_with_failure();
      end
    end
  endtask

  // Lane must sit idle with no result before any command
  task automatic check_idle();
    assert (!busy_o) else begin
      $display("ERR busy_o found 0x%h expected 0x0", busy_o);
      stop_with_failure();
    end
    assert (!result_valid_o) else begin
      $display("ERR result_valid_o found 0x%h expected 0x0", result_valid_o);
      stop_with_failure();
    end
  endtask

  task automatic drive_load(input logic [`LANE_VRF_AW-1:0] addr, input lane_pkg::elen_t data);
    @(negedge clk_i);
    check_idle();
    load_valid_i = 1'b1;
    load_addr_i  = addr;
    load_data_i  = data;
    @(negedge clk_i);
    load_valid_i = 1'b0;
  endtask

  // Field digits are op, vs1, vs2, vd and vl
  task automatic run_command(input logic [19:0] field);
    lane_pkg::lane_cmd_t cmd;
    int unsigned         cycles;
    cmd.op  = lane_pkg::vfu_op_e'(field[18:16]);
    cmd.vs1 = field[14:12];
    cmd.vs2 = field[10:8];
    cmd.vd  = field[6:4];
    cmd.vl  = field[3:0];
    assert (exp_q.size() == cmd.vl) else begin
      $display("Vector file lists %0d expected results for a command of length %0d",
               exp_q.size(), cmd.vl);
      stop_with_failure();
    end
    @(negedge clk_i);
    cmd_valid_i  = 1'b1;
    cmd_i        = cmd;
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
    cmd_count++;
    // Accepted command raises busy_o on the next cycle, even for an empty vector
    assert (busy_o) else begin
      $display("ERR busy_o found 0x%h expected 0x1", busy_o);
      stop_with_failure();
    end
    // Lane stays busy while results are still owed
    cycles = 0;
    while (exp_q.size() != 0) begin
      assert (busy_o) else begin
        $display("busy_o fell before all results had arrived");
        stop_with_failure();
      end
      cycles++;
      if (cycles > ResultTimeout) begin
        $display("Timed out waiting for a result from the lane");
        stop_with_failure();
      end
      @(negedge clk_i);
    end
    cycles = 0;
    while (busy_o) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > IdleTimeout) begin
        $display("busy_o did not fall after the last result");
        stop_with_failure();
      end
    end
  endtask

  initial begin
    load_valid_i = 1'b0;
    load_addr_i  = '0;
    load_data_i  = '0;
    cmd_valid_i  = 1'b0;
    cmd_i        = '0;
    cmd_count    = 0;
    for (int n = 0; n < NrVectors; n++) begin
      vec_mem[n] = '0;
    end
    $readmemh("test/lane_vectors.txt", vec_mem);
    wait_reset_release();
    repeat (4) begin
      @(negedge clk_i);
      check_idle();
    end
    // Kind 1 loads, kind 2 runs a command, kind 3 queues an expected result
    for (int n = 0; n < NrVectors; n++) begin
      case (vec_mem[n][87:84])
        4'h1: drive_load(vec_mem[n][64 +: `LANE_VRF_AW], vec_mem[n][63:0]);
        4'h2: run_command(vec_mem[n][83:64]);
        4'h3: exp_q.push_back(vec_mem[n][63:0]);
        default: ;
      endcase
    end
    if ((exp_q.size() == 0) && (cmd_count > 0)) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("Vector file ran %0d commands and left %0d expected results unused",
               cmd_count, exp_q.size());
      stop_with_failure();
    end
  end

endmodule

// File: test/tb_clock_gen.sv
// Testbench clock and reset source, 100 ns clock with reset held low for ten cycles
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  // Half of the 100 ns period
  localparam int unsigned HalfPeriod  = 50;
  localparam int unsigned ResetCycles = 10;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HalfPeriod);
      clk_o = ~clk_o;
    end
  end

  // Release on a falling edge, away from the active edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: rtl/vector_lane.sv
// Vector lane top: requester, VRF, two operand queues and element ALU
`timescale 1ns/10ps
`include "lane_defines.svh"

module vector_lane (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Host register load
  input  logic                    load_valid_i,
  input  logic [`LANE_VRF_AW-1:0] load_addr_i,
  input  lane_pkg::elen_t         load_data_i,
  // Host command
  input  logic                    cmd_valid_i,
  input  lane_pkg::lane_cmd_t     cmd_i,
  // Result stream
  input  logic                    result_ready_i,
  output logic                    busy_o,
  output lane_pkg::elen_t         result_o,
  output logic                    result_valid_o
);

  // Read request path
  logic                    rd_en;
  logic [`LANE_VRF_AW-1:0] rd_addr_a, rd_addr_b;
  logic                    rd_valid;
  lane_pkg::elen_t         rd_data_a, rd_data_b;

  // Queue handshakes
  logic                    queue_ready_a, queue_ready_b;
  lane_pkg::elen_t         operand_a, operand_b;
  logic                    valid_a, valid_b;
  logic                    pop;

  // Execution feedback
  lane_pkg::vrf_wr_t       wr;
  lane_pkg::lane_cmd_t     cmd_q;
  logic                    done;

  operand_requester i_operand_requester (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_i          (cmd_i),
    .queue_ready_a_i(queue_ready_a),
    .queue_ready_b_i(queue_ready_b),
    .done_i         (done),
    .rd_en_o        (rd_en),
    .rd_addr_a_o    (rd_addr_a),
    .rd_addr_b_o    (rd_addr_b),
    .cmd_o          (cmd_q),
    .busy_o         (busy_o)
  );

  vrf_bank i_vrf_bank (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_en_i     (rd_en),
    .rd_addr_a_i (rd_addr_a),
    .rd_addr_b_i (rd_addr_b),
    .rd_valid_o  (rd_valid),
    .rd_data_a_o (rd_data_a),
    .rd_data_b_o (rd_data_b),
    .wr_i        (wr),
    .load_valid_i(load_valid_i),
    .load_addr_i (load_addr_i),
    .load_data_i (load_data_i)
  );

  // Source one operands
  operand_queue queue_a (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .operand_i            (rd_data_a),
    .operand_valid_i      (rd_valid),
    .operand_issued_i     (rd_en),
    .operand_queue_ready_o(queue_ready_a),
    .operand_o            (operand_a),
    .operand_valid_o      (valid_a),
    .operand_ready_i      (pop)
  );

  // Source two operands
  operand_queue queue_b (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .operand_i            (rd_data_b),
    .operand_valid_i      (rd_valid),
    .operand_issued_i     (rd_en),
    .operand_queue_ready_o(queue_ready_b),
    .operand_o            (operand_b),
    .operand_valid_o      (valid_b),
    .operand_ready_i      (pop)
  );

  simd_alu i_simd_alu (
    .operand_a_i   (operand_a),
    .operand_b_i   (operand_b),
    .valid_a_i     (valid_a),
    .valid_b_i     (valid_b),
    .result_ready_i(result_ready_i),
    .cmd_i         (cmd_q),
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .pop_o         (pop),
    .wr_o          (wr),
    .result_o      (result_o),
    .result_valid_o(result_valid_o),
    .done_o        (done)
  );

endmodule

// File: rtl/simd_alu.sv
// SIMD element ALU: pops both operand queues and drives write-back and lane result
`timescale 1ns/10ps
`include "lane_defines.svh"

module simd_alu (
  input  lane_pkg::elen_t     operand_a_i,
  input  lane_pkg::elen_t     operand_b_i,
  input  logic                valid_a_i,
  input  logic                valid_b_i,
  input  logic                result_ready_i,
  input  lane_pkg::lane_cmd_t cmd_i,
  input  logic                clk_i,
  input  logic                rst_ni,
  output logic                pop_o,
  output lane_pkg::vrf_wr_t   wr_o,
  output lane_pkg::elen_t     result_o,
  output logic                result_valid_o,
  output logic                done_o
);

  logic [`LANE_VL_W-1:0] elem_q;
  lane_pkg::elen_t       res;

  // Both heads present and host not stalling
  assign pop_o = valid_a_i && valid_b_i && result_ready_i;

  // Element operation, add and sub wrap at ELEN
  always_comb begin
    case (cmd_i.op)
      lane_pkg::VADD: res = operand_a_i + operand_b_i;
      lane_pkg::VSUB: res = operand_a_i - operand_b_i;
      lane_pkg::VAND: res = operand_a_i & operand_b_i;
      lane_pkg::VOR:  res = operand_a_i | operand_b_i;
      lane_pkg::VXOR: res = operand_a_i ^ operand_b_i;
      default:        res = '0;
    endcase
  end

  // Write-back to vd at the current element
  assign wr_o.en   = pop_o;
  assign wr_o.addr = `LANE_VRF_AW'(cmd_i.vd) * `LANE_VRF_AW'(`LANE_VLMAX)
                     + `LANE_VRF_AW'(elem_q);
  assign wr_o.data = res;

  assign result_o       = res;
  assign result_valid_o = pop_o;
  // Last element of the vector
  assign done_o         = pop_o && (elem_q == cmd_i.vl - 1'b1);

  // Element index, back to zero after the last one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      elem_q <= '0;
    end else if (done_o) begin
      elem_q <= '0;
    end else if (pop_o) begin
      elem_q <= elem_q + 1'b1;
    end
  end

  // Paired reads keep both queues in step
  a_queues_in_step: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_a_i == valid_b_i);

endmodule

// File: rtl/operand_requester.sv
// Operand requester: command FSM issuing paired source reads under queue credits
`timescale 1ns/10ps
`include "lane_defines.svh"

module operand_requester (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Host command
  input  logic                    cmd_valid_i,
  input  lane_pkg::lane_cmd_t     cmd_i,
  // Credit grants and completion
  input  logic                    queue_ready_a_i,
  input  logic                    queue_ready_b_i,
  input  logic                    done_i,
  // VRF read request
  output logic                    rd_en_o,
  output logic [`LANE_VRF_AW-1:0] rd_addr_a_o,
  output logic [`LANE_VRF_AW-1:0] rd_addr_b_o,
  // Latched command for the ALU
  output lane_pkg::lane_cmd_t     cmd_o,
  output logic                    busy_o
);

  lane_pkg::req_state_e  state_q;
  lane_pkg::lane_cmd_t   cmd_q;
  logic [`LANE_VL_W-1:0] elem_q;
  logic                  all_issued;

  // Every element of the command has gone out to the VRF
  assign all_issued = (elem_q == cmd_q.vl);

  // One paired read per cycle while both queues hand out a credit
  assign rd_en_o = (state_q == lane_pkg::REQ_ISSUE) && !all_issued
                   && queue_ready_a_i && queue_ready_b_i;

  // Address is register times VLMAX plus element index
  assign rd_addr_a_o = `LANE_VRF_AW'(cmd_q.vs1) * `LANE_VRF_AW'(`LANE_VLMAX)
                       + `LANE_VRF_AW'(elem_q);
  assign rd_addr_b_o = `LANE_VRF_AW'(cmd_q.vs2) * `LANE_VRF_AW'(`LANE_VLMAX)
                       + `LANE_VRF_AW'(elem_q);

  assign cmd_o  = cmd_q;
  assign busy_o = (state_q == lane_pkg::REQ_ISSUE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= lane_pkg::REQ_IDLE;
      cmd_q   <= '0;
      elem_q  <= '0;
    end else begin
      case (state_q)
        lane_pkg::REQ_IDLE: begin
          // Latch the command, issue starts next cycle
          if (cmd_valid_i) begin
            cmd_q   <= cmd_i;
            elem_q  <= '0;
            state_q <= lane_pkg::REQ_ISSUE;
          end
        end
        lane_pkg::REQ_ISSUE: begin
          if (rd_en_o) begin
            elem_q <= elem_q + 1'b1;
          end
          // Stay busy until the last write-back, empty vectors leave at once
          if (all_issued && (done_i || (cmd_q.vl == '0))) begin
            state_q <= lane_pkg::REQ_IDLE;
          end
        end
        default: begin
          state_q <= lane_pkg::REQ_IDLE;
        end
      endcase
    end
  end

  // Host strobes a command only while the lane is idle
  a_cmd_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_i |-> !busy_o);

  // The ALU can only finish after every read went out
  a_done_after_issue: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |-> (busy_o && all_issued));

endmodule

// File: rtl/vrf_bank.sv
// Vector register file with two registered read ports and a shared write port
`timescale 1ns/10ps
`include "lane_defines.svh"

module vrf_bank (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Paired operand reads
  input  logic                    rd_en_i,
  input  logic [`LANE_VRF_AW-1:0] rd_addr_a_i,
  input  logic [`LANE_VRF_AW-1:0] rd_addr_b_i,
  output logic                    rd_valid_o,
  output lane_pkg::elen_t         rd_data_a_o,
  output lane_pkg::elen_t         rd_data_b_o,
  // ALU write-back
  input  lane_pkg::vrf_wr_t       wr_i,
  // Host load
  input  logic                    load_valid_i,
  input  logic [`LANE_VRF_AW-1:0] load_addr_i,
  input  lane_pkg::elen_t         load_data_i
);

  localparam int unsigned NrWords = `LANE_NR_VREGS * `LANE_VLMAX;

  // Element storage, one word per register element
  lane_pkg::elen_t mem_q [NrWords];

  lane_pkg::elen_t rd_data_a_q, rd_data_b_q;
  logic            rd_valid_q;

  // Write-back has priority, loads only come while the lane is idle
  always_ff @(posedge clk_i) begin
    if (wr_i.en) begin
      mem_q[wr_i.addr] <= wr_i.data;
    end else if (load_valid_i) begin
      mem_q[load_addr_i] <= load_data_i;
    end
  end

  // Read data follows the enable by one cycle
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_a_q <= mem_q[rd_addr_a_i];
      rd_data_b_q <= mem_q[rd_addr_b_i];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= rd_en_i;
    end
  end

  assign rd_valid_o  = rd_valid_q;
  assign rd_data_a_o = rd_data_a_q;
  assign rd_data_b_o = rd_data_b_q;

  // Host loads and write-back share one port
  a_single_writer: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wr_i.en && load_valid_i));

endmodule

// File: rtl/operand_queue.sv
// Operand queue: credit-counted element buffer between VRF read data and the ALU
`timescale 1ns/10ps
`include "lane_defines.svh"

module operand_queue (
  input  logic            clk_i,
  input  logic            rst_ni,
  // VRF side
  input  lane_pkg::elen_t operand_i,
  input  logic            operand_valid_i,
  input  logic            operand_issued_i,
  output logic            operand_queue_ready_o,
  // ALU side
  output lane_pkg::elen_t operand_o,
  output logic            operand_valid_o,
  input  logic            operand_ready_i
);

  localparam int unsigned CreditW = $clog2(`LANE_QUEUE_DEPTH + 1);

  logic               buf_empty;
  logic               buf_full;
  logic               buf_pop;
  logic [CreditW-1:0] credit_q;

  // Words land here one cycle after the read was issued
  operand_fifo #(
    .Depth(`LANE_QUEUE_DEPTH)
  ) i_operand_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (operand_valid_i),
    .pop_i  (buf_pop),
    .data_i (operand_i),
    .data_o (operand_o),
    .empty_o(buf_empty),
    .full_o (buf_full)
  );

  assign operand_valid_o = !buf_empty;
  // Single consumer, so its ready is the pop
  assign buf_pop         = operand_ready_i;

  // Credits count words in flight plus words stored
  // A pop in this cycle frees a slot, so the next read may go out now
  assign operand_queue_ready_o = (credit_q < CreditW'(`LANE_QUEUE_DEPTH)) || buf_pop;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= '0;
    end else begin
      case ({operand_issued_i, buf_pop})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  // Granted reads never exceed the buffer space
  a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= CreditW'(`LANE_QUEUE_DEPTH));

  // A full buffer means every credit is held by a stored word
  a_full_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    buf_full |-> (credit_q == CreditW'(`LANE_QUEUE_DEPTH)));

endmodule

// File: rtl/operand_fifo.sv
// Operand FIFO: circular element buffer with fill count and full/empty flags
`timescale 1ns/10ps

module operand_fifo #(
  parameter int unsigned Depth = 2
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            push_i,
  input  logic            pop_i,
  input  lane_pkg::elen_t data_i,
  output lane_pkg::elen_t data_o,
  output logic            empty_o,
  output logic            full_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  // Storage, payload only
  lane_pkg::elen_t mem_q [Depth];

  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] cnt_q;

  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == CntW'(Depth));
  // Head of queue straight from storage
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Pointers wrap at Depth, which need not be a power of two
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keeps the count
      if (push_i && !pop_i) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop_i && !push_i) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Producer must never overrun the buffer
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni) full_o |-> !push_i);

  // Consumer must never read an empty buffer
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni) empty_o |-> !pop_i);

endmodule

// File: rtl/lane_pkg.sv
// Lane package with element, opcode, FSM state and command types
`include "lane_defines.svh"

package lane_pkg;

  // One vector element
  typedef logic [`LANE_ELEN-1:0] elen_t;

  // Vector register index
  typedef logic [$clog2(`LANE_NR_VREGS)-1:0] vreg_t;

  // Element ALU operations
  typedef enum logic [2:0] {
    VADD,
    VSUB,
    VAND,
    VOR,
    VXOR
  } vfu_op_e;

  // Operand requester states
  typedef enum logic {
    REQ_IDLE,
    REQ_ISSUE
  } req_state_e;

  // Arithmetic command from the host, 16 bits
  typedef struct packed {
    vfu_op_e              op;
    vreg_t                vs1;
    vreg_t                vs2;
    vreg_t                vd;
    logic [`LANE_VL_W-1:0] vl;
  } lane_cmd_t;

  // VRF write port bundle, 71 bits
  typedef struct packed {
    logic                   en;
    logic [`LANE_VRF_AW-1:0] addr;
    elen_t                  data;
  } vrf_wr_t;

endpackage

// File: rtl/lane_defines.svh
// Lane configuration macros: element width, register file geometry and queue depth
`ifndef LANE_DEFINES_SVH
`define LANE_DEFINES_SVH

// Width of one vector element in bits
`define LANE_ELEN 64

// Architectural vector registers held by the lane
`define LANE_NR_VREGS 8

// Elements per vector register
`define LANE_VLMAX 8

// VRF word address, register number times VLMAX plus element index
`define LANE_VRF_AW 6

// Operand FIFO depth, also the credit limit of each queue
`define LANE_QUEUE_DEPTH 2

// Vector length field, wide enough for 0 up to VLMAX
`define LANE_VL_W 4

`endif
